//--- Bender.yml
package:
  name: dcache

sources:
  - dcache_cfg_pkg.sv
  - dcache_op_pkg.sv
  - dcache_req_buf.sv
  - dcache_way.sv
  - dcache_way_select.sv
  - dcache_fsm.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_dcache.sv

//--- dcache_cfg_pkg.sv
package dcache_cfg_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // defaults for the top level parameters
    localparam int index_w_def  = 4;   // 16 sets
    localparam int offset_w_def = 2;   // byte offset in a word
    localparam int ways_def     = 2;

endpackage

//--- dcache_fsm.sv
`timescale 1ns/1ps

module dcache_fsm #(
    parameter int ways = dcache_cfg_pkg::ways_def
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        valid,
    input  logic                        flush,
    input  logic                        buf_op,
    input  dcache_op_pkg::cacop_t       buf_cacop,
    input  logic                        buf_wr,
    input  logic                        buf_uncached,
    input  logic                        buf_addr0,
    input  logic                        any_hit,
    input  logic [$clog2(ways)-1:0]     hit_way,
    input  logic [$clog2(ways)-1:0]     lru_way,
    input  logic                        mem_addr_ok,
    input  logic                        mem_data_ok,
    output logic                        ready,
    output logic                        buf_we,
    output logic                        mem_req,
    output logic                        mem_wr,
    output logic [ways-1:0]             data_we,
    output logic [ways-1:0]             fill,
    output logic [ways-1:0]             inv,
    output logic [ways-1:0]             init,
    output logic                        use_en,
    output logic [$clog2(ways)-1:0]     use_way,
    output logic                        fill_sel,
    output logic                        rdata_valid,
    output logic                        op_done
);
    import dcache_op_pkg::*;

    fsm_state_t state_q;
    fsm_state_t state;
    fsm_state_t state_nxt;
    fsm_state_t done_nxt;
    logic       miss;

    // ops share the accept slot with lookups and are told apart by the buffered flag
    assign state = (state_q == st_lookup && buf_op) ? st_op : state_q;

    assign miss     = !any_hit || buf_uncached;
    assign done_nxt = valid ? st_lookup : st_idle;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_nxt;
        end
    end

    //////////////////////////////
    // next state

    always_comb begin
        state_nxt = st_idle;
        case (state)
            st_idle: state_nxt = done_nxt;
            st_lookup: begin
                if (flush) begin
                    state_nxt = st_flush;
                end else if (buf_wr) begin
                    if (mem_addr_ok) begin
                        state_nxt = done_nxt;
                    end else begin
                        state_nxt = miss ? st_miss_w : st_hit_w;
                    end
                end else if (miss) begin
                    state_nxt = mem_data_ok ? st_miss_r_fill : st_miss_r_wait;
                end else begin
                    state_nxt = done_nxt;
                end
            end
            st_op, st_flush: state_nxt = flush ? st_flush : done_nxt;
            st_hit_w, st_miss_w: state_nxt = mem_addr_ok ? done_nxt : state;
            st_miss_r_wait: state_nxt = mem_data_ok ? st_miss_r_fill : st_miss_r_wait;
            st_miss_r_fill: state_nxt = done_nxt;
            default: state_nxt = st_idle;
        endcase
    end

    //////////////////////////////
    // outputs

    always_comb begin
        ready       = 1'b0;
        mem_req     = 1'b0;
        mem_wr      = 1'b0;
        data_we     = '0;
        fill        = '0;
        inv         = '0;
        init        = '0;
        use_en      = 1'b0;
        use_way     = hit_way;
        fill_sel    = 1'b0;
        rdata_valid = 1'b0;
        op_done     = 1'b0;
        case (state)
            st_idle, st_flush: ready = 1'b1;
            st_lookup: begin
                if (flush) begin
                    ready = 1'b1;   // request dropped
                end else begin
                    if (buf_uncached && any_hit) begin
                        inv[hit_way] = 1'b1;
                    end
                    if (buf_wr) begin
                        mem_req = 1'b1;
                        mem_wr  = 1'b1;
                        ready   = mem_addr_ok;
                        if (!miss) begin
                            data_we[hit_way] = 1'b1;
                            use_en           = 1'b1;
                        end
                    end else if (miss) begin
                        mem_req = 1'b1;
                    end else begin
                        ready       = 1'b1;   // read hit
                        rdata_valid = 1'b1;
                        use_en      = 1'b1;
                    end
                end
            end
            st_op: begin
                ready = 1'b1;
                if (!flush) begin
                    op_done = 1'b1;
                    case (buf_cacop)
                        cacop_init:    init[buf_addr0] = 1'b1;
                        cacop_idx_inv: inv[buf_addr0]  = 1'b1;
                        cacop_hit_inv: inv[hit_way]    = any_hit;
                        default: ;
                    endcase
                end
            end
            st_hit_w, st_miss_w: begin
                mem_req = 1'b1;
                mem_wr  = 1'b1;
                ready   = mem_addr_ok;
            end
            st_miss_r_wait: mem_req = 1'b1;
            st_miss_r_fill: begin
                ready       = 1'b1;
                rdata_valid = 1'b1;
                fill_sel    = 1'b1;
                if (!buf_uncached) begin   // strongly ordered reads never allocate
                    fill[lru_way] = 1'b1;
                    use_en        = 1'b1;
                    use_way       = lru_way;
                end
            end
            default: ;
        endcase
        buf_we = ready;
    end

    // memory request held until acknowledged
    assert property (@(posedge clk) disable iff (!rstn)
        mem_req && mem_wr && !mem_addr_ok |=> mem_req && mem_wr)
        else $error("dcache_fsm: write request dropped before mem_addr_ok");

    assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_wr && !mem_data_ok |=> mem_req && !mem_wr)
        else $error("dcache_fsm: read request dropped before mem_data_ok");

    // no new request taken while a memory read is outstanding
    assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_wr |-> !ready)
        else $error("dcache_fsm: ready while a memory read is outstanding");

endmodule

//--- dcache_op_pkg.sv
package dcache_op_pkg;

    // main control states
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_op,
        st_flush,
        st_hit_w,
        st_miss_w,
        st_miss_r_wait,
        st_miss_r_fill
    } fsm_state_t;

    // cache maintenance codes
    typedef enum logic [1:0] {
        cacop_init,      // clear tag and valid
        cacop_idx_inv,   // invalidate by index, way from addr[0]
        cacop_hit_inv,   // invalidate the way that hits
        cacop_none
    } cacop_t;

endpackage

//--- dcache_req_buf.sv
`timescale 1ns/1ps

module dcache_req_buf (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                we,
    input  logic                                valid,
    input  logic                                op,
    input  dcache_op_pkg::cacop_t               cacop,
    input  logic [dcache_cfg_pkg::addr_w-1:0]   addr,
    input  logic                                wr,
    input  logic [dcache_cfg_pkg::data_w/8-1:0] wstrb,
    input  logic [dcache_cfg_pkg::data_w-1:0]   wdata,
    input  logic                                uncached,
    output logic                                buf_op,
    output dcache_op_pkg::cacop_t               buf_cacop,
    output logic [dcache_cfg_pkg::addr_w-1:0]   buf_addr,
    output logic                                buf_wr,
    output logic [dcache_cfg_pkg::data_w/8-1:0] buf_wstrb,
    output logic [dcache_cfg_pkg::data_w-1:0]   buf_wdata,
    output logic                                buf_uncached
);
    import dcache_op_pkg::*;

    logic capture;

    assign capture = we && valid;

    // request kind
    always_ff @(posedge clk) begin
        if (!rstn) begin
            buf_op    <= 1'b0;
            buf_cacop <= cacop_none;
        end else if (capture) begin
            buf_op    <= op;
            buf_cacop <= cacop;
        end
    end

    // payload stays put while the FSM is busy
    always_ff @(posedge clk) begin
        if (capture) begin
            buf_addr     <= addr;
            buf_wr       <= wr;
            buf_wstrb    <= wstrb;
            buf_wdata    <= wdata;
            buf_uncached <= uncached;
        end
    end

endmodule

//--- dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int index_w  = dcache_cfg_pkg::index_w_def,
    parameter int offset_w = dcache_cfg_pkg::offset_w_def,
    parameter int ways     = dcache_cfg_pkg::ways_def
) (
    input  logic                                clk,
    input  logic                                rstn,
    // pipeline side
    input  logic                                valid,
    input  logic                                op,
    input  dcache_op_pkg::cacop_t               cacop,
    input  logic [dcache_cfg_pkg::addr_w-1:0]   addr,
    input  logic                                wr,
    input  logic [dcache_cfg_pkg::data_w/8-1:0] wstrb,
    input  logic [dcache_cfg_pkg::data_w-1:0]   wdata,
    input  logic                                uncached,
    input  logic                                flush,
    output logic                                ready,
    output logic [dcache_cfg_pkg::data_w-1:0]   rdata,
    output logic                                rdata_valid,
    output logic                                op_done,
    output logic                                stall,
    // memory side
    output logic                                mem_req,
    output logic                                mem_wr,
    output logic [dcache_cfg_pkg::addr_w-1:0]   mem_addr,
    output logic [dcache_cfg_pkg::data_w-1:0]   mem_wdata,
    output logic [dcache_cfg_pkg::data_w/8-1:0] mem_wstrb,
    input  logic                                mem_addr_ok,
    input  logic                                mem_data_ok,
    input  logic [dcache_cfg_pkg::data_w-1:0]   mem_rdata
);
    import dcache_cfg_pkg::*;
    import dcache_op_pkg::*;

    localparam int way_w = $clog2(ways);

    logic                 buf_we;
    logic                 buf_op;
    cacop_t               buf_cacop;
    logic [addr_w-1:0]    buf_addr;
    logic                 buf_wr;
    logic [data_w/8-1:0]  buf_wstrb;
    logic [data_w-1:0]    buf_wdata;
    logic                 buf_uncached;

    logic [ways-1:0]        hit;
    logic [ways*data_w-1:0] way_rdata;
    logic [ways-1:0]        data_we;
    logic [ways-1:0]        fill;
    logic [ways-1:0]        inv;
    logic [ways-1:0]        init;

    logic               any_hit;
    logic [way_w-1:0]   hit_way;
    logic [way_w-1:0]   lru_way;
    logic [way_w-1:0]   use_way;
    logic               use_en;
    logic               fill_sel;
    logic [data_w-1:0]  fill_word;

    assign stall     = ~ready;
    assign mem_addr  = buf_addr;
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = buf_wstrb;

    // refill word kept for the fill cycle after mem_data_ok
    always_ff @(posedge clk) begin
        if (mem_data_ok) begin
            fill_word <= mem_rdata;
        end
    end

    dcache_req_buf req_buf_i (
        .clk          (clk),
        .rstn         (rstn),
        .we           (buf_we),
        .valid        (valid),
        .op           (op),
        .cacop        (cacop),
        .addr         (addr),
        .wr           (wr),
        .wstrb        (wstrb),
        .wdata        (wdata),
        .uncached     (uncached),
        .buf_op       (buf_op),
        .buf_cacop    (buf_cacop),
        .buf_addr     (buf_addr),
        .buf_wr       (buf_wr),
        .buf_wstrb    (buf_wstrb),
        .buf_wdata    (buf_wdata),
        .buf_uncached (buf_uncached)
    );

    for (genvar g = 0; g < ways; g++) begin : g_way
        dcache_way #(
            .index_w  (index_w),
            .offset_w (offset_w)
        ) way_i (
            .clk       (clk),
            .rstn      (rstn),
            .addr      (buf_addr),
            .wdata     (buf_wdata),
            .wstrb     (buf_wstrb),
            .fill_data (fill_word),
            .data_we   (data_we[g]),
            .fill      (fill[g]),
            .inv       (inv[g]),
            .init      (init[g]),
            .hit       (hit[g]),
            .rdata     (way_rdata[g*data_w +: data_w])
        );
    end

    dcache_way_select #(
        .index_w (index_w),
        .ways    (ways)
    ) way_select_i (
        .clk       (clk),
        .rstn      (rstn),
        .index     (buf_addr[offset_w +: index_w]),
        .hit       (hit),
        .way_rdata (way_rdata),
        .mem_rdata (fill_word),
        .fill_sel  (fill_sel),
        .use_en    (use_en),
        .use_way   (use_way),
        .any_hit   (any_hit),
        .hit_way   (hit_way),
        .lru_way   (lru_way),
        .rdata     (rdata)
    );

    dcache_fsm #(
        .ways (ways)
    ) fsm_i (
        .clk          (clk),
        .rstn         (rstn),
        .valid        (valid),
        .flush        (flush),
        .buf_op       (buf_op),
        .buf_cacop    (buf_cacop),
        .buf_wr       (buf_wr),
        .buf_uncached (buf_uncached),
        .buf_addr0    (buf_addr[0]),
        .any_hit      (any_hit),
        .hit_way      (hit_way),
        .lru_way      (lru_way),
        .mem_addr_ok  (mem_addr_ok),
        .mem_data_ok  (mem_data_ok),
        .ready        (ready),
        .buf_we       (buf_we),
        .mem_req      (mem_req),
        .mem_wr       (mem_wr),
        .data_we      (data_we),
        .fill         (fill),
        .inv          (inv),
        .init         (init),
        .use_en       (use_en),
        .use_way      (use_way),
        .fill_sel     (fill_sel),
        .rdata_valid  (rdata_valid),
        .op_done      (op_done)
    );

endmodule

//--- dcache_way.sv
`timescale 1ns/1ps

module dcache_way #(
    parameter int index_w  = dcache_cfg_pkg::index_w_def,
    parameter int offset_w = dcache_cfg_pkg::offset_w_def
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic [dcache_cfg_pkg::addr_w-1:0]   addr,
    input  logic [dcache_cfg_pkg::data_w-1:0]   wdata,
    input  logic [dcache_cfg_pkg::data_w/8-1:0] wstrb,
    input  logic [dcache_cfg_pkg::data_w-1:0]   fill_data,
    input  logic                                data_we,
    input  logic                                fill,
    input  logic                                inv,
    input  logic                                init,
    output logic                                hit,
    output logic [dcache_cfg_pkg::data_w-1:0]   rdata
);
    import dcache_cfg_pkg::*;

    localparam int sets  = 2 ** index_w;
    localparam int tag_w = addr_w - index_w - offset_w;

    logic [sets-1:0]   valid_q;
    logic [tag_w-1:0]  tag_q  [sets];
    logic [data_w-1:0] data_q [sets];

    logic [index_w-1:0] idx;
    logic [tag_w-1:0]   tag;

    assign idx = addr[offset_w +: index_w];
    assign tag = addr[addr_w-1 -: tag_w];

    assign hit   = valid_q[idx] && (tag_q[idx] == tag);
    assign rdata = data_q[idx];

    //////////////////////////////
    // tag and valid

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (init || inv) begin
            valid_q[idx] <= 1'b0;
        end else if (fill) begin
            valid_q[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (init) begin
            tag_q[idx] <= '0;
        end else if (fill) begin
            tag_q[idx] <= tag;
        end
    end

    //////////////////////////////
    // data

    always_ff @(posedge clk) begin
        if (fill) begin
            data_q[idx] <= fill_data;   // refill takes the whole word
        end else if (data_we) begin
            for (int b = 0; b < data_w / 8; b++) begin
                if (wstrb[b]) begin
                    data_q[idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- dcache_way_select.sv
`timescale 1ns/1ps

module dcache_way_select #(
    parameter int index_w = dcache_cfg_pkg::index_w_def,
    parameter int ways    = dcache_cfg_pkg::ways_def
) (
    input  logic                                     clk,
    input  logic                                     rstn,
    input  logic [index_w-1:0]                       index,
    input  logic [ways-1:0]                          hit,
    input  logic [ways*dcache_cfg_pkg::data_w-1:0]   way_rdata,
    input  logic [dcache_cfg_pkg::data_w-1:0]        mem_rdata,
    input  logic                                     fill_sel,
    input  logic                                     use_en,
    input  logic [$clog2(ways)-1:0]                  use_way,
    output logic                                     any_hit,
    output logic [$clog2(ways)-1:0]                  hit_way,
    output logic [$clog2(ways)-1:0]                  lru_way,
    output logic [dcache_cfg_pkg::data_w-1:0]        rdata
);
    import dcache_cfg_pkg::*;

    localparam int way_w = $clog2(ways);
    localparam int sets  = 2 ** index_w;

    logic [sets-1:0] lru_q;   // points at the next victim

    assign any_hit = |hit;

    always_comb begin
        hit_way = '0;
        for (int i = 0; i < ways; i++) begin
            if (hit[i]) begin
                hit_way = way_w'(i);
            end
        end
    end

    // refill word bypasses the arrays
    assign rdata = fill_sel ? mem_rdata : way_rdata[hit_way*data_w +: data_w];

    // one bit per set, two ways
    assign lru_way = lru_q[index];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (use_en) begin
            lru_q[index] <= ~use_way[0];
        end
    end

    // a tag lives in one way only, fills happen on misses
    assert property (@(posedge clk) disable iff (!rstn) $onehot0(hit))
        else $error("dcache_way_select: hit vector %b has more than one way", hit);

endmodule

//--- sources.f
dcache_cfg_pkg.sv
dcache_op_pkg.sv
dcache_req_buf.sv
dcache_way.sv
dcache_way_select.sv
dcache_fsm.sv
dcache_top.sv
tb_dcache.sv

//--- tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
    import dcache_cfg_pkg::*;
    import dcache_op_pkg::*;

    localparam int n_rand = 40;
    localparam int n_req  = n_rand + 32;
    localparam int period = 100;

    // expected outcome of a request
    localparam logic [1:0] k_none = 2'd0;
    localparam logic [1:0] k_hit  = 2'd1;
    localparam logic [1:0] k_miss = 2'd2;
    localparam logic [1:0] k_op   = 2'd3;

    logic clk = 1'b0;
    logic rstn;
    logic valid, op, wr, uncached, flush;
    cacop_t cacop;
    logic [addr_w-1:0] addr;
    logic [data_w/8-1:0] wstrb;
    logic [data_w-1:0] wdata, rdata;
    logic ready, rdata_valid, op_done, stall;
    logic mem_req, mem_wr, mem_addr_ok, mem_data_ok;
    logic [addr_w-1:0] mem_addr;
    logic [data_w-1:0] mem_wdata, mem_rdata;
    logic [data_w/8-1:0] mem_wstrb;

    logic [1:0]          exp_kind;
    logic [31:0]         lfsr_q = 32'h53ac3be6;
    logic [data_w-1:0]   shadow [256];
    logic [addr_w-1:0]   rd_addr_q, wr_addr_q;
    logic [data_w-1:0]   wr_data_q;
    logic [data_w/8-1:0] wr_strb_q;
    int                  wr_accepted, wr_acked;

    dcache_top #(
        .index_w  (index_w_def),
        .offset_w (offset_w_def),
        .ways     (ways_def)
    ) dcache_top_i (
        .clk (clk), .rstn (rstn),
        .valid (valid), .op (op), .cacop (cacop), .addr (addr), .wr (wr),
        .wstrb (wstrb), .wdata (wdata), .uncached (uncached), .flush (flush),
        .ready (ready), .rdata (rdata), .rdata_valid (rdata_valid),
        .op_done (op_done), .stall (stall),
        .mem_req (mem_req), .mem_wr (mem_wr), .mem_addr (mem_addr),
        .mem_wdata (mem_wdata), .mem_wstrb (mem_wstrb),
        .mem_addr_ok (mem_addr_ok), .mem_data_ok (mem_data_ok), .mem_rdata (mem_rdata)
    );

    initial begin
        forever #(period / 2) clk = ~clk;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] get_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h80200003 : 32'h0);
        end
        return r;
    endfunction

    //////////////////////////////
    // memory model

    always begin
        int  cnt;
        int  idx;
        bit  busy;
        @(posedge clk);
        #20;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        idx = mem_addr[9:2];
        if (!rstn) begin
            busy = 1'b0;
        end else if (mem_req) begin
            if (!busy) begin
                busy = 1'b1;
                cnt  = mem_wr ? get_bits(2) : get_bits(2) + 1;
            end
            if (cnt == 0) begin
                busy = 1'b0;
                if (mem_wr) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_wstrb[b]) shadow[idx][8*b +: 8] = mem_wdata[8*b +: 8];
                    end
                    mem_addr_ok = 1'b1;
                end else begin
                    mem_rdata   = shadow[idx];
                    mem_data_ok = 1'b1;
                end
            end else begin
                cnt--;
            end
        end
    end

    // last accepted read and write
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_accepted <= 0;
            wr_acked    <= 0;
        end else begin
            if (valid && ready && !op && !wr) rd_addr_q <= addr;
            if (valid && ready && !op && wr && !flush) begin
                wr_addr_q   <= addr;
                wr_data_q   <= wdata;
                wr_strb_q   <= wstrb;
                wr_accepted <= wr_accepted + 1;
            end
            if (mem_req && mem_wr && mem_addr_ok) wr_acked <= wr_acked + 1;
        end
    end

    //////////////////////////////
    // checks

    assert property (@(posedge clk) $rose(rstn) |-> ready && !mem_req)
        else report_fail($sformatf("Fail ready/mem_req after reset: %h/%h",
            $sampled(ready), $sampled(mem_req)));

    assert property (@(posedge clk) disable iff (!rstn) stall == !ready)
        else report_fail($sformatf("Fail stall: got %h with ready %h",
            $sampled(stall), $sampled(ready)));

    assert property (@(posedge clk) disable iff (!rstn)
        rdata_valid |-> rdata == shadow[rd_addr_q[9:2]])
        else report_fail($sformatf("Fail rdata: got %h expected %h at addr %h",
            $sampled(rdata), shadow[$sampled(rd_addr_q[9:2])], $sampled(rd_addr_q)));

    assert property (@(posedge clk) disable iff (!rstn)
        valid && ready && exp_kind == k_hit |=> rdata_valid && !mem_req)
        else report_fail($sformatf("Fail hit: rdata_valid %h mem_req %h at addr %h",
            $sampled(rdata_valid), $sampled(mem_req), $sampled(rd_addr_q)));

    assert property (@(posedge clk) disable iff (!rstn)
        valid && ready && exp_kind == k_miss |=> mem_req && !mem_wr)
        else report_fail($sformatf("Fail miss: mem_req %h mem_wr %h at addr %h",
            $sampled(mem_req), $sampled(mem_wr), $sampled(rd_addr_q)));

    assert property (@(posedge clk) disable iff (!rstn)
        valid && ready && exp_kind == k_op |=> op_done && ready)
        else report_fail($sformatf("Fail op_done: got %h ready %h",
            $sampled(op_done), $sampled(ready)));

    assert property (@(posedge clk) disable iff (!rstn)
        valid && ready && wr && !op && !flush |=> mem_req && mem_wr
            && mem_addr == wr_addr_q && mem_wdata == wr_data_q && mem_wstrb == wr_strb_q)
        else report_fail($sformatf("Fail mem write: addr %h/%h wdata %h/%h wstrb %h/%h",
            $sampled(mem_addr), $sampled(wr_addr_q), $sampled(mem_wdata),
            $sampled(wr_data_q), $sampled(mem_wstrb), $sampled(wr_strb_q)));

    assert property (@(posedge clk) disable iff (!rstn)
        flush |-> ready && !mem_req && !rdata_valid && !op_done)
        else report_fail($sformatf("Fail flush: ready %h mem_req %h rdata_valid %h op_done %h",
            $sampled(ready), $sampled(mem_req), $sampled(rdata_valid), $sampled(op_done)));

    //////////////////////////////
    // stimulus

    task automatic do_req(input logic is_op, input cacop_t c, input logic [31:0] a,
                          input logic w, input logic [3:0] s, input logic [31:0] d,
                          input logic u, input logic [1:0] k);
        valid    = 1'b1;
        op       = is_op;
        cacop    = c;
        addr     = a;
        wr       = w;
        wstrb    = s;
        wdata    = d;
        uncached = u;
        exp_kind = k;
        do begin
            @(negedge clk);
        end while (!ready);
        @(posedge clk);
        #10;
        valid    = 1'b0;
        exp_kind = k_none;
    endtask

    task automatic read(input logic [31:0] a, input logic u, input logic [1:0] k);
        do_req(1'b0, cacop_none, a, 1'b0, 4'h0, 32'h0, u, k);
    endtask

    task automatic write(input logic [31:0] a, input logic [3:0] s, input logic [31:0] d,
                         input logic u);
        do_req(1'b0, cacop_none, a, 1'b1, s, d, u, k_none);
    endtask

    task automatic cache_op(input cacop_t c, input logic [31:0] a, input logic [1:0] k);
        do_req(1'b1, c, a, 1'b0, 4'h0, 32'h0, 1'b0, k);
    endtask

    task automatic wait_idle();
        do begin
            @(negedge clk);
        end while (!ready || mem_req);
        @(posedge clk);
        #10;
    endtask

    initial begin
        logic [31:0] r;
        logic [3:0]  strb;
        logic [31:0] data;
        logic        unc;
        for (int i = 0; i < 256; i++) begin
            r = i << 2;
            shadow[i] = (r * 32'h9e3779b1) ^ {r[7:0], ~r[15:8], 16'hc35a};
        end
        rstn        = 1'b0;
        valid       = 1'b0;
        op          = 1'b0;
        cacop       = cacop_none;
        addr        = '0;
        wr          = 1'b0;
        wstrb       = '0;
        wdata       = '0;
        uncached    = 1'b0;
        flush       = 1'b0;
        exp_kind    = k_none;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        repeat (4) @(posedge clk);
        #10 rstn = 1'b1;
        @(posedge clk);
        #10;

        // lru at set 1
        read(32'h004, 1'b0, k_miss);
        read(32'h004, 1'b0, k_hit);
        read(32'h044, 1'b0, k_miss);
        read(32'h004, 1'b0, k_hit);
        read(32'h084, 1'b0, k_miss);
        read(32'h004, 1'b0, k_hit);
        read(32'h044, 1'b0, k_miss);

        // write around then write hit
        write(32'h008, 4'b1111, 32'hdeadbeef, 1'b0);
        read(32'h008, 1'b0, k_miss);
        write(32'h008, 4'b0011, 32'h1234abcd, 1'b0);
        read(32'h008, 1'b0, k_hit);
        write(32'h048, 4'b1100, 32'h55aa0000, 1'b1);

        // uncached reads never allocate
        read(32'h00c, 1'b0, k_miss);
        read(32'h00c, 1'b1, k_miss);
        read(32'h00c, 1'b0, k_miss);
        read(32'h00c, 1'b1, k_miss);
        read(32'h00c, 1'b0, k_miss);
        read(32'h00c, 1'b0, k_hit);

        // hit and index invalidate in fresh set 4
        read(32'h010, 1'b0, k_miss);        // way 0
        cache_op(cacop_hit_inv, 32'h010, k_op);
        read(32'h010, 1'b0, k_miss);        // refills way 1
        read(32'h010, 1'b0, k_hit);
        cache_op(cacop_idx_inv, 32'h011, k_op);
        read(32'h010, 1'b0, k_miss);

        // index init
        read(32'h014, 1'b0, k_miss);
        cache_op(cacop_init, 32'h014, k_op);
        read(32'h014, 1'b0, k_miss);

        // flush drops everything
        wait_idle();
        flush = 1'b1;
        read(32'h004, 1'b0, k_none);
        read(32'h100, 1'b0, k_none);
        cache_op(cacop_hit_inv, 32'h004, k_none);
        repeat (2) @(posedge clk);
        #10 flush = 1'b0;
        read(32'h004, 1'b0, k_hit);

        for (int n = 0; n < n_rand; n++) begin
            r = {22'b0, 8'(get_bits(8)), 2'b00};
            if (get_bits(1)) begin
                strb = 4'(get_bits(4));
                data = get_bits(32);
                unc  = 1'(get_bits(1));
                write(r, strb, data, unc);
            end else begin
                unc = 1'(get_bits(1));
                read(r, unc, k_none);
            end
        end
        wait_idle();

        if (wr_accepted != wr_acked) begin
            report_fail($sformatf("Fail write count: accepted %h acknowledged %h",
                wr_accepted, wr_acked));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

    initial begin
        #(n_req * 20 * period + 10 * period);
        report_fail("timeout: the cache stopped making progress");
    end

endmodule
